//--- all.f
+incdir+logic
logic/crypt_pkg.sv
logic/feistel_round.sv
logic/block_engine.sv
logic/buffer_arbiter.sv
logic/block_buffer.sv
logic/pipe_port.sv
logic/crypt_top.sv
tests/crypt_properties.sv
tests/crypt_tb.sv

//--- Bender.yml
package:
  name: crypt_accel

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/crypt_pkg.sv
      - logic/feistel_round.sv
      - logic/block_engine.sv
      - logic/buffer_arbiter.sv
      - logic/block_buffer.sv
      - logic/pipe_port.sv
      - logic/crypt_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/crypt_properties.sv
      - tests/crypt_tb.sv

//--- tests/crypt_tb.sv
// ----------------------------------------
// testbench for the cipher accelerator that checks
// random blocks against a model of the Feistel rule
// ----------------------------------------
`default_nettype none
`timescale 1ns/10ps
`include "crypt_defines.svh"

module crypt_tb
	import crypt_pkg::*;
();

	localparam int NWORDS = 2 * `CRYPT_BLOCKS;

	logic        okClk;
	logic        ram_reset;
	logic [63:0] key;
	logic        decrypt;
	logic        start;
	logic        pipe_in_write;
	word_t       pipe_in_data;
	logic        pipe_out_read;
	word_t       pipe_out_data;
	logic        done;
	round_t      round_sel;

	// stimulus state and the words the host expects back
	logic [31:0] rng;
	word_t       plain [NWORDS];
	word_t       cipher [NWORDS];
	word_t       expect_words [NWORDS];
	word_t       scratch;
	int          errors;
	int          checks;
	int          tests_run;
	int          done_pulses;
	int          err_mark;
	int          pulse_mark;

	crypt_top uut (
		.okClk(okClk), .ram_reset(ram_reset), .key(key), .decrypt(decrypt),
		.start(start), .pipe_in_write(pipe_in_write), .pipe_in_data(pipe_in_data),
		.pipe_out_read(pipe_out_read), .pipe_out_data(pipe_out_data),
		.done(done), .round_sel(round_sel)
	);

	// timing and arbitration checks sit inside the top level
	bind crypt_top crypt_properties props (
		.okClk(okClk), .ram_reset(ram_reset), .start(start), .done(done),
		.in_req(in_req), .out_req(out_req), .eng_req(eng_req), .eng_gnt(eng_gnt),
		.mem_we(mem_we), .in_addr(in_addr), .out_addr(out_addr), .mem_addr(mem_addr),
		.pipe_out_data(pipe_out_data)
	);

	// 100 ns clock
	always #50 okClk = ~okClk;

	// every done pulse is counted so a run can be checked for exactly one
	always @(posedge okClk) begin
		if (done) done_pulses <= done_pulses + 1;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// low word of the 64-bit key after a left rotate by 4*i
	function automatic logic [31:0] round_key_of(input logic [63:0] k, input int i);
		logic [63:0] rot;
		rot = (i == 0) ? k : ((k << (4 * i)) | (k >> (64 - 4 * i)));
		return rot[31:0];
	endfunction

	// xor with the key, substitute nibbles, rotate left by 5
	function automatic logic [31:0] feistel_f(input logic [31:0] r, input logic [31:0] k);
		logic [31:0] x;
		logic [31:0] y;
		x = r ^ k;
		for (int n = 0; n < 8; n++) begin
			y[4*n +: 4] = nibble_sub[x[4*n +: 4]];
		end
		return (y << 5) | (y >> 27);
	endfunction

	// one block goes forward through all rounds with L as the high word
	// the result comes out swapped so its low word is the final L
	task automatic encrypt_block(input word_t lo, input word_t hi,
		output word_t out_lo, output word_t out_hi);
		logic [31:0] l;
		logic [31:0] r;
		logic [31:0] t;
		l = hi;
		r = lo;
		for (int i = 0; i < `CRYPT_ROUNDS; i++) begin
			t = r;
			r = l ^ feistel_f(r, round_key_of(key, i));
			l = t;
		end
		out_lo = l;
		out_hi = r;
	endtask

	task automatic model_encrypt();
		for (int b = 0; b < `CRYPT_BLOCKS; b++) begin
			encrypt_block(plain[2*b], plain[2*b+1], expect_words[2*b], expect_words[2*b+1]);
		end
	endtask

	// ----------------------------------------
	// host side of the pipes
	// ----------------------------------------

	task automatic write_word(input word_t w);
		@(posedge okClk);
		pipe_in_write <= 1'b1;
		pipe_in_data <= w;
		@(posedge okClk);
		pipe_in_write <= 1'b0;
	endtask

	// data is valid one edge after the edge that sampled the strobe
	task automatic read_word(output word_t w);
		@(posedge okClk);
		pipe_out_read <= 1'b1;
		@(posedge okClk);
		pipe_out_read <= 1'b0;
		@(posedge okClk);
		@(negedge okClk);
		w = pipe_out_data;
	endtask

	task automatic fill_random();
		for (int i = 0; i < NWORDS; i++) begin
			rng = xorshift32(rng);
			plain[i] = rng;
			write_word(plain[i]);
		end
	endtask

	task automatic pulse_start();
		@(posedge okClk);
		start <= 1'b1;
		@(posedge okClk);
		start <= 1'b0;
	endtask

	// done is looked at in the middle of each cycle
	task automatic wait_done(input int limit);
		int   waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < limit) begin
			@(negedge okClk);
			seen = done;
			waited++;
		end
		if (!seen) begin
			$display("timeout: the engine never raised done within %0d cycles", limit);
			$display("Regression failed");
			$finish;
		end
	endtask

	// the activity display leaves zero once the core steps past its first round
	task automatic wait_busy(input int limit);
		int   waited;
		logic busy;
		waited = 0;
		busy = 1'b0;
		while (!busy && waited < limit) begin
			@(negedge okClk);
			busy = (round_sel != '0);
			waited++;
		end
		if (!busy) begin
			$display("timeout: round_sel never left zero within %0d cycles", limit);
			$display("Regression failed");
			$finish;
		end
	endtask

	task automatic apply_reset();
		@(posedge okClk);
		ram_reset <= 1'b1;
		repeat (5) @(posedge okClk);
		ram_reset <= 1'b0;
	endtask

	// ----------------------------------------
	// checking and reporting
	// ----------------------------------------

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// the out pointer walks the whole output region and wraps back to 16
	task automatic check_readback();
		word_t w;
		for (int i = 0; i < NWORDS; i++) begin
			read_word(w);
			check_word($sformatf("pipe_out_data[%0d]", i), w, expect_words[i]);
		end
	endtask

	task automatic report_test(input string name, input int mark);
		tests_run++;
		$display("test %0d %s: %s", tests_run, name, (errors == mark) ? "ok" : "mismatch");
	endtask

	// ----------------------------------------
	// scenario sequence
	// ----------------------------------------
	initial begin
		okClk = 1'b0;
		ram_reset = 1'b1;
		key = '0;
		decrypt = 1'b0;
		start = 1'b0;
		pipe_in_write = 1'b0;
		pipe_in_data = '0;
		pipe_out_read = 1'b0;
		rng = 32'd13791;
		errors = 0;
		checks = 0;
		tests_run = 0;
		done_pulses = 0;
		repeat (5) @(posedge okClk);
		ram_reset <= 1'b0;
		rng = xorshift32(rng);
		key[63:32] <= rng;
		rng = xorshift32(rng);
		key[31:0] <= rng;

		// plain encrypt of one buffer of random words
		err_mark = errors;
		fill_random();
		model_encrypt();
		pulse_start();
		wait_done(2000);
		check_readback();
		report_test("encrypt", err_mark);
		for (int i = 0; i < NWORDS; i++) cipher[i] = expect_words[i];

		// the ciphertext goes back in and must decrypt to the plaintext
		err_mark = errors;
		for (int i = 0; i < NWORDS; i++) write_word(cipher[i]);
		@(posedge okClk);
		decrypt <= 1'b1;
		for (int i = 0; i < NWORDS; i++) expect_words[i] = plain[i];
		pulse_start();
		wait_done(2000);
		check_readback();
		report_test("decrypt round trip", err_mark);

		// a full lap of host reads competes with the engine for the buffer
		err_mark = errors;
		@(posedge okClk);
		decrypt <= 1'b0;
		fill_random();
		model_encrypt();
		pulse_mark = done_pulses;
		pulse_start();
		fork
			wait_done(3000);
			begin
				for (int k = 0; k < NWORDS; k++) read_word(scratch);
			end
		join
		check_readback();
		check_word("done pulse count", done_pulses - pulse_mark, 1);
		report_test("stall under pipe traffic", err_mark);

		// move the out pointer off 16 and cut a run short in the middle of block 0
		// then reset must idle the engine and bring both the pointer and round_sel back
		err_mark = errors;
		for (int k = 0; k < 3; k++) read_word(scratch);
		pulse_start();
		wait_busy(200);
		apply_reset();
		@(negedge okClk);
		check_word("round_sel", round_sel, '0);
		pulse_mark = done_pulses;
		read_word(scratch);
		check_word("pipe_out_data after reset", scratch, expect_words[0]);
		// an engine left running would finish its blocks well inside this window
		repeat (2 * `CRYPT_BLOCKS * `CRYPT_ROUNDS) @(posedge okClk);
		check_word("done pulses after reset", done_pulses - pulse_mark, 0);
		report_test("pointer reset", err_mark);

		repeat (2) @(posedge okClk);
		$display("tests %0d, checks %0d, errors %0d, property failures %0d",
			tests_run, checks, errors, uut.props.fails);
		if (errors == 0 && uut.props.fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/crypt_properties.sv
// ----------------------------------------
// bound timing and arbitration assertions
// ----------------------------------------
`default_nettype none
`timescale 1ns/10ps

module crypt_properties
	import crypt_pkg::*;
(
	input wire        okClk,
	input wire        ram_reset,
	input wire        start,
	input wire        done,
	input wire        in_req,
	input wire        out_req,
	input wire        eng_req,
	input wire        eng_gnt,
	input wire        mem_we,
	input wire addr_t in_addr,
	input wire addr_t out_addr,
	input wire addr_t mem_addr,
	input wire word_t pipe_out_data
);

	// failure tally, read by the testbench at the end of the run
	int unsigned fails;
	logic        run_armed;

	initial fails = 0;

	// a run is armed by start and used up by its done pulse
	always_ff @(posedge okClk) begin
		if (ram_reset) run_armed <= 1'b0;
		else if (start) run_armed <= 1'b1;
		else if (done) run_armed <= 1'b0;
	end

	// ----------------------------------------
	// run end
	// ----------------------------------------
	done_one_cycle: assert property (@(posedge okClk) disable iff (ram_reset)
		done |=> !done) else begin
		$error("done stayed high for more than one cycle");
		fails++;
	end

	done_after_start: assert property (@(posedge okClk) disable iff (ram_reset)
		done |-> run_armed) else begin
		$error("done rose with no start before it");
		fails++;
	end

	// ----------------------------------------
	// buffer arbitration
	// ----------------------------------------

	// pipe requests own the buffer port in the cycle they are raised
	in_granted: assert property (@(posedge okClk) disable iff (ram_reset)
		in_req |-> (mem_we && mem_addr == in_addr)) else begin
		$error("pipe-in request did not reach the buffer in its own cycle");
		fails++;
	end

	out_granted: assert property (@(posedge okClk) disable iff (ram_reset)
		(out_req && !in_req) |-> (!mem_we && mem_addr == out_addr)) else begin
		$error("pipe-out request did not reach the buffer in its own cycle");
		fails++;
	end

	single_grant: assert property (@(posedge okClk) disable iff (ram_reset)
		!(in_req && out_req) && !(eng_gnt && (in_req || out_req || !eng_req))) else begin
		$error("buffer granted to more than one requester");
		fails++;
	end

	// the host word only moves two edges after a sampled read strobe
	out_data_hold: assert property (@(posedge okClk) disable iff (ram_reset)
		$changed(pipe_out_data) |-> $past(out_req, 2)) else begin
		$error("pipe_out_data changed without a pipe-out read");
		fails++;
	end

endmodule

`default_nettype wire

//--- logic/crypt_top.sv
// ----------------------------------------
// cipher accelerator top level
// ----------------------------------------
`default_nettype none
`timescale 1ns/10ps

module crypt_top
	import crypt_pkg::*;
(
	input  wire        okClk,
	input  wire        ram_reset,
	input  wire [63:0] key,
	input  wire        decrypt,
	input  wire        start,
	input  wire        pipe_in_write,
	input  wire word_t pipe_in_data,
	input  wire        pipe_out_read,
	output word_t      pipe_out_data,
	output logic       done,
	output round_t     round_sel
);

	// ----------------------------------------
	// buffer requests
	// ----------------------------------------
	logic  in_req;
	logic  out_req;
	addr_t in_addr;
	addr_t out_addr;
	logic  eng_req;
	logic  eng_we;
	addr_t eng_addr;
	word_t eng_wdata;
	logic  eng_gnt;

	// buffer port, rdata fans out to the engine and the pipe-out hold
	addr_t mem_addr;
	logic  mem_we;
	word_t mem_wdata;
	word_t rdata;

	// core controls, round_sel doubles as the round index
	logic   core_load;
	logic   core_step;
	block_t core_in;
	block_t core_out;

	pipe_port u_pipe (
		.okClk(okClk), .ram_reset(ram_reset),
		.pipe_in_write(pipe_in_write), .pipe_out_read(pipe_out_read),
		.in_req(in_req), .out_req(out_req), .in_addr(in_addr), .out_addr(out_addr)
	);

	block_engine u_engine (
		.okClk(okClk), .ram_reset(ram_reset), .start(start),
		.eng_req(eng_req), .eng_we(eng_we), .eng_addr(eng_addr), .eng_wdata(eng_wdata),
		.eng_gnt(eng_gnt), .rdata(rdata),
		.core_load(core_load), .core_step(core_step), .round_idx(round_sel),
		.core_in(core_in), .core_out(core_out), .done(done)
	);

	buffer_arbiter u_arbiter (
		.okClk(okClk), .ram_reset(ram_reset),
		.in_req(in_req), .out_req(out_req), .eng_req(eng_req),
		.in_addr(in_addr), .out_addr(out_addr), .eng_addr(eng_addr),
		.pipe_in_data(pipe_in_data), .eng_wdata(eng_wdata), .eng_we(eng_we),
		.rdata(rdata), .eng_gnt(eng_gnt),
		.mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
		.pipe_out_data(pipe_out_data)
	);

	block_buffer u_buffer (
		.okClk(okClk), .mem_addr(mem_addr), .mem_we(mem_we),
		.mem_wdata(mem_wdata), .rdata(rdata)
	);

	feistel_round u_core (
		.okClk(okClk), .ram_reset(ram_reset),
		.load(core_load), .step(core_step), .decrypt(decrypt),
		.round_idx(round_sel), .key(key), .block_in(core_in), .block_out(core_out)
	);

endmodule

`default_nettype wire

//--- logic/pipe_port.sv
// ----------------------------------------
// pipe-in and pipe-out address pointers
// ----------------------------------------
`default_nettype none
`timescale 1ns/10ps
`include "crypt_defines.svh"

module pipe_port
	import crypt_pkg::*;
(
	input  wire okClk,
	input  wire ram_reset,
	input  wire pipe_in_write,
	input  wire pipe_out_read,
	output logic  in_req,
	output logic  out_req,
	output addr_t in_addr,
	output addr_t out_addr
);

	// each region holds two words per block
	localparam int PTR_W = $clog2(2 * `CRYPT_BLOCKS);

	logic [PTR_W-1:0] in_ptr;
	logic [PTR_W-1:0] out_ptr;

	// each strobe becomes a request at the current pointer in the same cycle
	assign in_req = pipe_in_write;
	assign out_req = pipe_out_read;

	// the top address bit picks the region, so out_ptr zero is word 16
	assign in_addr = {1'b0, in_ptr};
	assign out_addr = {1'b1, out_ptr};

	// pointers move past the word once its request has gone out
	// and wrap inside their own region
	always_ff @(posedge okClk) begin
		if (ram_reset) begin
			in_ptr <= '0;
			out_ptr <= '0;
		end else begin
			if (pipe_in_write) in_ptr <= in_ptr + 1'b1;
			if (pipe_out_read) out_ptr <= out_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/block_buffer.sv
// ----------------------------------------
// single-port 32-word buffer RAM, registered read
// ----------------------------------------
`default_nettype none
`timescale 1ns/10ps
`include "crypt_defines.svh"

module block_buffer
	import crypt_pkg::*;
(
	input  wire        okClk,
	input  wire addr_t mem_addr,
	input  wire        mem_we,
	input  wire word_t mem_wdata,
	output word_t      rdata
);

	// words 0 to 15 hold plaintext, 16 to 31 hold the results
	word_t mem [2**`CRYPT_ADDR_W];

	// read-first behaviour like a block RAM port
	// rdata is valid the cycle after the address is sampled
	always_ff @(posedge okClk) begin
		if (mem_we) mem[mem_addr] <= mem_wdata;
		rdata <= mem[mem_addr];
	end

endmodule

`default_nettype wire

//--- logic/buffer_arbiter.sv
// ----------------------------------------
// fixed-priority buffer arbiter, pipe-in then
// pipe-out then engine, with pipe-out data hold
// ----------------------------------------
`default_nettype none
`timescale 1ns/10ps

module buffer_arbiter
	import crypt_pkg::*;
(
	input  wire        okClk,
	input  wire        ram_reset,
	input  wire        in_req,
	input  wire        out_req,
	input  wire        eng_req,
	input  wire addr_t in_addr,
	input  wire addr_t out_addr,
	input  wire addr_t eng_addr,
	input  wire word_t pipe_in_data,
	input  wire word_t eng_wdata,
	input  wire        eng_we,
	input  wire word_t rdata,
	output logic       eng_gnt,
	output addr_t      mem_addr,
	output logic       mem_we,
	output word_t      mem_wdata,
	output word_t      pipe_out_data
);

	// owner of the read whose data is on rdata this cycle
	typedef enum logic [1:0] {own_none, own_out, own_eng} owner_t;

	logic   in_gnt;
	logic   out_gnt;
	owner_t rd_owner;

	// the host never strobes both pipes at once, so pipe grants never wait
	assign in_gnt = in_req;
	assign out_gnt = out_req & ~in_req;
	assign eng_gnt = eng_req & ~in_req & ~out_req;

	// only the pipe-in and engine paths ever write
	assign mem_addr = in_gnt ? in_addr : (out_gnt ? out_addr : eng_addr);
	assign mem_we = in_gnt | (eng_gnt & eng_we);
	assign mem_wdata = in_gnt ? pipe_in_data : eng_wdata;

	// pipe_out_data loads only when rdata belongs to a pipe-out read,
	// so engine traffic never disturbs what the host is reading
	always_ff @(posedge okClk) begin
		if (ram_reset) begin
			rd_owner <= own_none;
			pipe_out_data <= '0;
		end else begin
			if (out_gnt) rd_owner <= own_out;
			else if (eng_gnt && !eng_we) rd_owner <= own_eng;
			else rd_owner <= own_none;
			if (rd_owner == own_out) pipe_out_data <= rdata;
		end
	end

endmodule

`default_nettype wire

//--- logic/block_engine.sv
// ----------------------------------------
// block engine FSM, reads each block, runs the
// core and stores the result, then pulses done
// ----------------------------------------
`default_nettype none
`timescale 1ns/10ps
`include "crypt_defines.svh"

module block_engine
	import crypt_pkg::*;
(
	input  wire         okClk,
	input  wire         ram_reset,
	input  wire         start,
	output logic        eng_req,
	output logic        eng_we,
	output addr_t       eng_addr,
	output word_t       eng_wdata,
	input  wire         eng_gnt,
	input  wire word_t  rdata,
	output logic        core_load,
	output logic        core_step,
	output round_t      round_idx,
	output block_t      core_in,
	input  wire block_t core_out,
	output logic        done
);

	localparam int BLK_W = $clog2(`CRYPT_BLOCKS);

	// the capture states sit one cycle behind a granted read
	// because the buffer has a registered read port
	typedef enum logic [2:0] {
		s_idle,
		s_rd_lo,
		s_cap_lo,
		s_rd_hi,
		s_cap_hi,
		s_run,
		s_wr_lo,
		s_wr_hi
	} state_t;

	state_t           state;
	logic [BLK_W-1:0] blk;
	round_t           round_cnt;
	word_t            lo_word;
	logic             wr_region;
	logic             hi_half;

	// ----------------------------------------
	// buffer request and core controls
	// ----------------------------------------

	// requests stay up in the request states until the arbiter grants them
	assign eng_req = (state == s_rd_lo) || (state == s_rd_hi) ||
		(state == s_wr_lo) || (state == s_wr_hi);
	assign eng_we = (state == s_wr_lo) || (state == s_wr_hi);

	// address is region bit, block index, then the half within the block
	assign wr_region = eng_we;
	assign hi_half = (state == s_rd_hi) || (state == s_wr_hi);
	assign eng_addr = {wr_region, blk, hi_half};

	// the core holds its result while the writes wait for a grant
	assign eng_wdata = hi_half ? core_out[2*`CRYPT_WORD_W-1:`CRYPT_WORD_W]
		: core_out[`CRYPT_WORD_W-1:0];

	// the upper word arrives on rdata in the same cycle the core loads
	assign core_in = {rdata, lo_word};
	assign core_load = (state == s_cap_hi);
	assign core_step = (state == s_run);
	assign round_idx = round_cnt;

	// ----------------------------------------
	// state sequence
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (ram_reset) begin
			state <= s_idle;
			blk <= '0;
			round_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				// start is only looked at here, so a busy run ignores it
				s_idle: begin
					if (start) begin
						blk <= '0;
						state <= s_rd_lo;
					end
				end
				s_rd_lo: begin
					if (eng_gnt) state <= s_cap_lo;
				end
				s_cap_lo: begin
					state <= s_rd_hi;
				end
				s_rd_hi: begin
					if (eng_gnt) state <= s_cap_hi;
				end
				s_cap_hi: begin
					round_cnt <= '0;
					state <= s_run;
				end
				// round counter wraps back to zero after the last round
				s_run: begin
					round_cnt <= round_cnt + 1'b1;
					if (round_cnt == round_t'(`CRYPT_ROUNDS - 1)) state <= s_wr_lo;
				end
				s_wr_lo: begin
					if (eng_gnt) state <= s_wr_hi;
				end
				s_wr_hi: begin
					if (eng_gnt) begin
						if (blk == BLK_W'(`CRYPT_BLOCKS - 1)) begin
							done <= 1'b1;
							state <= s_idle;
						end else begin
							blk <= blk + 1'b1;
							state <= s_rd_lo;
						end
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// low word of the block, taken the cycle after its read grant
	always_ff @(posedge okClk) begin
		if (state == s_cap_lo) lo_word <= rdata;
	end

endmodule

`default_nettype wire

//--- logic/feistel_round.sv
// ----------------------------------------
// Feistel core, one keyed round per clock
// over a 64-bit block held in L and R
// ----------------------------------------
`default_nettype none
`timescale 1ns/10ps
`include "crypt_defines.svh"

module feistel_round
	import crypt_pkg::*;
(
	input  wire         okClk,
	input  wire         ram_reset,
	input  wire         load,
	input  wire         step,
	input  wire         decrypt,
	input  wire round_t round_idx,
	input  wire [63:0]  key,
	input  wire block_t block_in,
	output block_t      block_out
);

	word_t  l_reg;
	word_t  r_reg;
	round_t key_idx;
	word_t  round_key;

	// round key i is the low word of the key rotated left by 4*i
	// the doubled key turns the rotate into a plain shift
	function automatic word_t key_sched(input logic [63:0] k, input round_t idx);
		logic [127:0] dbl;
		dbl = {k, k} << (4 * idx);
		return dbl[95:64];
	endfunction

	// round function: mix in the key, substitute each nibble, rotate left by 5
	function automatic word_t f_func(input word_t r, input word_t k);
		word_t x;
		word_t y;
		x = r ^ k;
		for (int i = 0; i < `CRYPT_WORD_W / 4; i++) begin
			y[4*i +: 4] = nibble_sub[x[4*i +: 4]];
		end
		return {y[`CRYPT_WORD_W-6:0], y[`CRYPT_WORD_W-1 -: 5]};
	endfunction

	// decrypt walks the same schedule backwards, 15 down to 0
	assign key_idx = decrypt ? round_t'(`CRYPT_ROUNDS - 1) - round_idx : round_idx;
	assign round_key = key_sched(key, key_idx);

	// ----------------------------------------
	// round state
	// ----------------------------------------

	// load takes the block with L as the upper word
	// each step maps (L,R) to (R, L xor F(R,K))
	always_ff @(posedge okClk) begin
		if (ram_reset) begin
			l_reg <= '0;
			r_reg <= '0;
		end else if (load) begin
			l_reg <= block_in[2*`CRYPT_WORD_W-1:`CRYPT_WORD_W];
			r_reg <= block_in[`CRYPT_WORD_W-1:0];
		end else if (step) begin
			l_reg <= r_reg;
			r_reg <= l_reg ^ f_func(r_reg, round_key);
		end
	end

	// the halves come out swapped after the last round
	assign block_out = {r_reg, l_reg};

endmodule

`default_nettype wire

//--- logic/crypt_pkg.sv
// ----------------------------------------
// cipher accelerator types and nibble table
// ----------------------------------------
`default_nettype none
`include "crypt_defines.svh"

package crypt_pkg;

	// one buffer word
	typedef logic [`CRYPT_WORD_W-1:0] word_t;

	// one buffer address
	typedef logic [`CRYPT_ADDR_W-1:0] addr_t;

	// one cipher block, the low word sits at the even address
	typedef logic [2*`CRYPT_WORD_W-1:0] block_t;

	// round index, also shown on the activity display
	typedef logic [$clog2(`CRYPT_ROUNDS)-1:0] round_t;

	// fixed 4-bit substitution used by the round function
	localparam logic [3:0] nibble_sub [16] = '{
		4'he, 4'h4, 4'hd, 4'h1, 4'h2, 4'hf, 4'hb, 4'h8,
		4'h3, 4'ha, 4'h6, 4'hc, 4'h5, 4'h9, 4'h0, 4'h7
	};

endpackage

`default_nettype wire

//--- logic/crypt_defines.svh
// ----------------------------------------
// cipher accelerator sizing macros shared by
// the RTL and the testbench
// ----------------------------------------
`ifndef CRYPT_DEFINES_SVH
`define CRYPT_DEFINES_SVH

// width of one buffer word and of each Feistel half
`define CRYPT_WORD_W 32

// buffer address width, 32 words in total
`define CRYPT_ADDR_W 5

// blocks ciphered per run
// the input region holds words 0 to 15 and the output region words 16 to 31
`define CRYPT_BLOCKS 8

// Feistel rounds applied to every block
`define CRYPT_ROUNDS 16

`endif
